// File: logic/l1_dcache_defs.svh
`ifndef L1_DCACHE_DEFS_SVH
`define L1_DCACHE_DEFS_SVH

// address split of the 64-bit byte address
`define L1_TAG_BITS    52
`define L1_INDEX_BITS  6
`define L1_OFFSET_BITS 6

// direct mapped, one tag entry per set
`define L1_SETS        64

// request queue entries, also the credits the processor starts with
`define L1_QUEUE_DEPTH 4

`endif

// File: logic/l1_dcache_pkg.sv
`include "l1_dcache_defs.svh"

package l1_dcache_pkg;

        // the line offset never reaches the tag side
        typedef struct packed {
                logic [`L1_TAG_BITS-1:0]   tag;
                logic [`L1_INDEX_BITS-1:0] index;
                logic                      write;
        } cpu_req_t;

        typedef struct packed {
                logic [`L1_TAG_BITS-1:0]   tag;
                logic [`L1_INDEX_BITS-1:0] index;
                logic                      write;
                logic                      hit;
        } cpu_resp_t;

        // valid sits in bit 0 of the tag word
        typedef struct packed {
                logic [`L1_TAG_BITS-1:0] tag;
                logic                    dirty;
                logic                    valid;
        } tag_entry_t;

        typedef struct packed {
                logic [`L1_TAG_BITS-1:0]   tag;
                logic [`L1_INDEX_BITS-1:0] index;
        } l2_req_t;

        // victim is the entry found in the set whether it is valid or not
        typedef struct packed {
                cpu_req_t   req;
                logic       hit;
                tag_entry_t victim;
        } lookup_t;

endpackage

// File: logic/l1_request_queue.sv
`timescale 1ns/1ps

`include "l1_dcache_defs.svh"

module l1_request_queue import l1_dcache_pkg::*; (
        input  logic     clk,
        input  logic     nrst,
        input  cpu_req_t cpu_req,
        input  logic     cpu_req_valid,
        output logic     credit_return,
        output cpu_req_t head_req,
        output logic     head_valid,
        input  logic     pop
);
        localparam int PTR_BITS = $clog2(`L1_QUEUE_DEPTH);
        localparam int CNT_BITS = $clog2(`L1_QUEUE_DEPTH + 1);

        cpu_req_t            mem [`L1_QUEUE_DEPTH];
        logic [PTR_BITS-1:0] wr_ptr;
        logic [PTR_BITS-1:0] rd_ptr;
        logic [CNT_BITS-1:0] count;

        function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
                if (ptr == PTR_BITS'(`L1_QUEUE_DEPTH - 1)) begin
                        return '0;
                end
                return ptr + 1'b1;
        endfunction

        assign head_req   = mem[rd_ptr];
        assign head_valid = (count != '0);

        always_ff @(posedge clk) begin
                if (cpu_req_valid) begin
                        mem[wr_ptr] <= cpu_req;
                end
        end

        always_ff @(posedge clk) begin
                if (!nrst) begin
                        wr_ptr        <= '0;
                        rd_ptr        <= '0;
                        count         <= '0;
                        credit_return <= 1'b0;
                end else begin
                        // every entry that leaves hands one credit back
                        credit_return <= pop;
                        if (cpu_req_valid) begin
                                wr_ptr <= next_ptr(wr_ptr);
                        end
                        if (pop) begin
                                rd_ptr <= next_ptr(rd_ptr);
                        end
                        case ({cpu_req_valid, pop})
                        2'b10: count <= count + 1'b1;
                        2'b01: count <= count - 1'b1;
                        default: count <= count;
                        endcase
                end
        end

        // the processor has no credit left when the queue is full
        a_no_push_full: assert property (@(posedge clk) disable iff (!nrst)
                cpu_req_valid |-> (count != CNT_BITS'(`L1_QUEUE_DEPTH)));

        a_no_pop_empty: assert property (@(posedge clk) disable iff (!nrst)
                pop |-> head_valid);

endmodule

// File: logic/l1_tag_array.sv
`timescale 1ns/1ps

`include "l1_dcache_defs.svh"

module l1_tag_array import l1_dcache_pkg::*; (
        input  logic                      clk,
        input  logic                      nrst,
        input  logic                      flush,
        input  cpu_req_t                  head_req,
        input  logic                      head_valid,
        output logic                      pop,
        input  logic                      busy,
        output lookup_t                   lookup,
        output logic                      lookup_valid,
        input  logic                      fill_en,
        input  logic [`L1_INDEX_BITS-1:0] fill_index,
        input  tag_entry_t                fill_entry,
        input  logic                      mark_dirty
);
        logic [`L1_TAG_BITS-1:0] tag_q [`L1_SETS];
        logic [`L1_SETS-1:0]     valid_q;
        logic [`L1_SETS-1:0]     dirty_q;
        cpu_req_t                req_q;
        logic                    req_pend;
        logic                    idle;
        tag_entry_t              stored;

        // one request at a time between the queue head and the response
        assign idle = !req_pend && !lookup_valid && !busy;
        assign pop  = head_valid && idle;

        assign stored.tag   = tag_q[req_q.index];
        assign stored.dirty = dirty_q[req_q.index];
        assign stored.valid = valid_q[req_q.index];

        always_ff @(posedge clk) begin
                if (pop) begin
                        req_q <= head_req;
                end
        end

        always_ff @(posedge clk) begin
                if (!nrst) begin
                        req_pend     <= 1'b0;
                        lookup_valid <= 1'b0;
                end else begin
                        req_pend     <= pop;
                        lookup_valid <= req_pend;
                end
        end

        // the compare is registered so the controller sees it one cycle later
        always_ff @(posedge clk) begin
                if (req_pend) begin
                        lookup.req    <= req_q;
                        lookup.hit    <= stored.valid && (stored.tag == req_q.tag);
                        lookup.victim <= stored;
                end
        end

        always_ff @(posedge clk) begin
                if (fill_en) begin
                        tag_q[fill_index] <= fill_entry.tag;
                end
        end

        always_ff @(posedge clk) begin
                if (!nrst) begin
                        valid_q <= '0;
                        dirty_q <= '0;
                end else if (flush && idle) begin
                        // dirty lines are dropped and the tags stay in place
                        valid_q <= '0;
                end else if (fill_en) begin
                        valid_q[fill_index] <= fill_entry.valid;
                        dirty_q[fill_index] <= fill_entry.dirty;
                end else if (mark_dirty) begin
                        // req_q still names the set of the last lookup
                        dirty_q[req_q.index] <= 1'b1;
                end
        end

        // the processor side only flushes with nothing in the pipe
        a_flush_idle: assert property (@(posedge clk) disable iff (!nrst)
                flush |-> !busy && !req_pend && !lookup_valid);

endmodule

// File: logic/l1_miss_controller.sv
`timescale 1ns/1ps

`include "l1_dcache_defs.svh"

module l1_miss_controller import l1_dcache_pkg::*; (
        input  logic                      clk,
        input  logic                      nrst,
        input  lookup_t                   lookup,
        input  logic                      lookup_valid,
        output logic                      busy,
        output logic                      stall,
        output logic                      fill_en,
        output logic [`L1_INDEX_BITS-1:0] fill_index,
        output tag_entry_t                fill_entry,
        output logic                      mark_dirty,
        output logic                      update,
        output logic                      refill,
        output l2_req_t                   l2_req,
        output logic                      l2_read,
        output logic                      l2_write,
        input  logic                      l2_ready,
        output cpu_resp_t                 resp,
        output logic                      resp_valid
);
        typedef enum logic [1:0] {
                ST_IDLE,
                ST_WRITEBACK,
                ST_REFILL,
                ST_RESPOND
        } state_t;

        state_t  state;
        lookup_t cur;
        logic    miss;
        logic    victim_wb;

        assign miss      = lookup_valid && !lookup.hit;
        assign victim_wb = lookup.victim.valid && lookup.victim.dirty;

        assign busy       = (state != ST_IDLE);
        assign stall      = busy || miss;
        assign mark_dirty = lookup_valid && lookup.hit && lookup.req.write;

        // the refilled line is clean unless a store brought it in
        assign fill_index       = cur.req.index;
        assign fill_entry.tag   = cur.req.tag;
        assign fill_entry.dirty = cur.req.write;
        assign fill_entry.valid = 1'b1;

        always_ff @(posedge clk) begin
                if (lookup_valid) begin
                        cur <= lookup;
                end
        end

        always_ff @(posedge clk) begin
                if (!nrst) begin
                        state      <= ST_IDLE;
                        l2_read    <= 1'b0;
                        l2_write   <= 1'b0;
                        fill_en    <= 1'b0;
                        refill     <= 1'b0;
                        update     <= 1'b0;
                        resp_valid <= 1'b0;
                end else begin
                        fill_en    <= 1'b0;
                        refill     <= 1'b0;
                        update     <= 1'b0;
                        resp_valid <= 1'b0;
                        case (state)
                        ST_IDLE: begin
                                if (lookup_valid && lookup.hit) begin
                                        update     <= lookup.req.write;
                                        resp_valid <= 1'b1;
                                end else if (miss && victim_wb) begin
                                        l2_write <= 1'b1;
                                        state    <= ST_WRITEBACK;
                                end else if (miss) begin
                                        l2_read <= 1'b1;
                                        state   <= ST_REFILL;
                                end
                        end
                        ST_WRITEBACK: begin
                                if (l2_ready) begin
                                        l2_write <= 1'b0;
                                        l2_read  <= 1'b1;
                                        state    <= ST_REFILL;
                                end
                        end
                        ST_REFILL: begin
                                if (l2_ready) begin
                                        l2_read <= 1'b0;
                                        fill_en <= 1'b1;
                                        refill  <= 1'b1;
                                        state   <= ST_RESPOND;
                                end
                        end
                        default: begin
                                resp_valid <= 1'b1;
                                state      <= ST_IDLE;
                        end
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (state == ST_IDLE && miss) begin
                        // a dirty victim goes out first under its own tag
                        l2_req <= {victim_wb ? lookup.victim.tag : lookup.req.tag,
                                   lookup.req.index};
                end else if (state == ST_WRITEBACK && l2_ready) begin
                        l2_req <= {cur.req.tag, cur.req.index};
                end
        end

        always_ff @(posedge clk) begin
                if (lookup_valid && lookup.hit) begin
                        resp <= {lookup.req, 1'b1};
                end else if (state == ST_RESPOND) begin
                        resp <= {cur.req, 1'b0};
                end
        end

        a_l2_one_kind: assert property (@(posedge clk) disable iff (!nrst)
                !(l2_read && l2_write));

        // L2 may take the address on any cycle until it raises ready
        a_l2_req_hold: assert property (@(posedge clk) disable iff (!nrst)
                (l2_read || l2_write) && !l2_ready |=> $stable(l2_req));

endmodule

// File: logic/l1_dcache.sv
`timescale 1ns/1ps

`include "l1_dcache_defs.svh"

module l1_dcache import l1_dcache_pkg::*; (
        input  logic      clk,
        input  logic      nrst,
        input  logic      flush,
        input  cpu_req_t  cpu_req,
        input  logic      cpu_req_valid,
        output logic      credit_return,
        output cpu_resp_t resp,
        output logic      resp_valid,
        output logic      stall,
        output logic      refill,
        output logic      update,
        output l2_req_t   l2_req,
        output logic      l2_read,
        output logic      l2_write,
        input  logic      l2_ready
);
        cpu_req_t                  head_req;
        logic                      head_valid;
        logic                      pop;
        logic                      busy;
        lookup_t                   lookup;
        logic                      lookup_valid;
        logic                      fill_en;
        logic [`L1_INDEX_BITS-1:0] fill_index;
        tag_entry_t                fill_entry;
        logic                      mark_dirty;

        l1_request_queue u_queue (
                .clk, .nrst, .cpu_req, .cpu_req_valid, .credit_return,
                .head_req, .head_valid, .pop
        );

        l1_tag_array u_tags (
                .clk, .nrst, .flush, .head_req, .head_valid, .pop, .busy,
                .lookup, .lookup_valid, .fill_en, .fill_index, .fill_entry, .mark_dirty
        );

        l1_miss_controller u_ctrl (
                .clk, .nrst, .lookup, .lookup_valid, .busy, .stall,
                .fill_en, .fill_index, .fill_entry, .mark_dirty, .update, .refill,
                .l2_req, .l2_read, .l2_write, .l2_ready, .resp, .resp_valid
        );

endmodule

// File: tb/l1_dcache_clock_gen.sv
`timescale 1ns/1ps

module l1_dcache_clock_gen #(
        parameter int RESET_CYCLES = 10
) (
        output logic clk,
        output logic nrst
);
        initial begin
                clk = 1'b0;
                forever begin
                        #5 clk = ~clk;
                end
        end

        // reset is released just after an edge, like every other input
        initial begin
                nrst = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                #1 nrst = 1'b1;
        end

endmodule

// File: tb/l1_dcache_tb.sv
`timescale 1ns/1ps

`include "l1_dcache_defs.svh"

module l1_dcache_tb import l1_dcache_pkg::*; ();
        localparam int N_ROWS = 11;
        localparam int N_BURSTS = 4;
        localparam int TIMEOUT = 200;
        localparam logic [1:0] OP_READ = 2'd0;
        localparam logic [1:0] OP_WRITE = 2'd1;
        localparam logic [1:0] OP_FLUSH = 2'd2;

        typedef struct packed {
                logic [1:0]                op;
                logic [`L1_TAG_BITS-1:0]   tag;
                logic [`L1_INDEX_BITS-1:0] index;
                logic                      hit;
        } row_t;

        logic clk, nrst, flush, cpu_req_valid, credit_return, resp_valid;
        logic stall, refill, update, l2_read, l2_write, l2_ready;
        cpu_req_t  cpu_req;
        cpu_resp_t resp;
        l2_req_t   l2_req;

        row_t                    rows [N_ROWS];
        string                   names [N_ROWS];
        logic [`L1_TAG_BITS-1:0] model_tag [`L1_SETS];
        logic [`L1_SETS-1:0]     model_valid, model_dirty;
        cpu_resp_t               exp_resp_q [$], act_resp_q [$];
        l2_req_t                 exp_l2_q [$], act_l2_q [$];
        logic                    exp_wr_q [$], act_wr_q [$];
        logic [`L1_INDEX_BITS-1:0] burst_index [4] = '{6'd5, 6'd9, 6'd12, 6'd40};
        int   credits, test_errors, total_errors, failed_tests, n_tests;
        int   exp_misses, exp_store_hits, wait_cnt;
        logic saw_refill, saw_update, saw_stall, timed_out, waiting;
        logic [15:0] stim_lfsr, delay_lfsr;

        l1_dcache_clock_gen u_clk (.clk, .nrst);

        l1_dcache dut (
                .clk, .nrst, .flush, .cpu_req, .cpu_req_valid, .credit_return,
                .resp, .resp_valid, .stall, .refill, .update,
                .l2_req, .l2_read, .l2_write, .l2_ready
        );

        function automatic logic [15:0] galois_step(input logic [15:0] s);
                return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
        endfunction

        task automatic draw_bits(inout logic [15:0] state, input int nbits, output int value);
                value = 0;
                for (int i = 0; i < nbits; i++) begin
                        value = (value << 1) | state[0];
                        state = galois_step(state);
                end
        endtask

        task automatic check_resp(input string name, input cpu_resp_t exp, input cpu_resp_t act);
                if (act !== exp) begin
                        $display("error: %s resp expected %h actual %h", name, exp, act);
                        test_errors++;
                end
        endtask

        task automatic check_l2(input string name, input l2_req_t exp, input logic exp_wr,
                                input l2_req_t act, input logic act_wr);
                if ({exp_wr, exp} !== {act_wr, act}) begin
                        $display("error: %s l2 expected %s %h actual %s %h", name,
                                 exp_wr ? "write" : "read", exp,
                                 act_wr ? "write" : "read", act);
                        test_errors++;
                end
        endtask

        task automatic check_bit(input string name, input logic exp, input logic act);
                if (act !== exp) begin
                        $display("error: %s expected %b actual %b", name, exp, act);
                        test_errors++;
                end
        endtask

        // the reference model keeps one tag entry per set
        task automatic model_access(input cpu_req_t req, output logic hit);
                logic [`L1_INDEX_BITS-1:0] idx;
                idx = req.index;
                hit = model_valid[idx] && (model_tag[idx] == req.tag);
                exp_resp_q.push_back({req, hit});
                if (hit) begin
                        model_dirty[idx] = model_dirty[idx] | req.write;
                        exp_store_hits += req.write;
                end else begin
                        if (model_valid[idx] && model_dirty[idx]) begin
                                exp_l2_q.push_back({model_tag[idx], idx});
                                exp_wr_q.push_back(1'b1);
                        end
                        exp_l2_q.push_back({req.tag, idx});
                        exp_wr_q.push_back(1'b0);
                        model_tag[idx] = req.tag;
                        model_valid[idx] = 1'b1;
                        model_dirty[idx] = req.write;
                        exp_misses++;
                end
        endtask

        task automatic send_req(input cpu_req_t req);
                int n;
                n = 0;
                while (credits == 0 && n < TIMEOUT && !timed_out) begin
                        @(posedge clk);
                        #1;
                        n++;
                end
                if (credits == 0) begin
                        $display("timeout: no credit came back for the next request");
                        timed_out = 1'b1;
                end else if (!timed_out) begin
                        cpu_req = req;
                        cpu_req_valid = 1'b1;
                        credits--;
                        @(posedge clk);
                        #1;
                        cpu_req_valid = 1'b0;
                end
        endtask

        task automatic wait_done();
                int n;
                n = 0;
                while (act_resp_q.size() < exp_resp_q.size() && n < TIMEOUT && !timed_out) begin
                        @(posedge clk);
                        #1;
                        n++;
                end
                if (act_resp_q.size() < exp_resp_q.size()) begin
                        $display("timeout: a response never arrived");
                        timed_out = 1'b1;
                end
        endtask

        task automatic start_test();
                test_errors = 0;
                exp_misses = 0;
                exp_store_hits = 0;
                saw_refill = 1'b0;
                saw_update = 1'b0;
                saw_stall = 1'b0;
        endtask

        task automatic finish_test(input string name);
                if (act_resp_q.size() != exp_resp_q.size() ||
                    act_l2_q.size() != exp_l2_q.size()) begin
                        $display("error: %s resp/l2 counts expected %0d/%0d actual %0d/%0d",
                                 name, exp_resp_q.size(), exp_l2_q.size(),
                                 act_resp_q.size(), act_l2_q.size());
                        test_errors++;
                end
                for (int i = 0; i < exp_resp_q.size() && i < act_resp_q.size(); i++) begin
                        check_resp(name, exp_resp_q[i], act_resp_q[i]);
                end
                for (int i = 0; i < exp_l2_q.size() && i < act_l2_q.size(); i++) begin
                        check_l2(name, exp_l2_q[i], exp_wr_q[i], act_l2_q[i], act_wr_q[i]);
                end
                check_bit({name, " refill"}, exp_misses > 0, saw_refill);
                check_bit({name, " stall"}, exp_misses > 0, saw_stall);
                check_bit({name, " update"}, exp_store_hits > 0, saw_update);
                check_bit({name, " all credits back"}, 1'b1, credits == `L1_QUEUE_DEPTH);
                if (test_errors == 0) begin
                        $display("test %s ok", name);
                end else begin
                        $display("test %s failed with %0d errors", name, test_errors);
                        failed_tests++;
                end
                total_errors += test_errors;
                n_tests++;
                exp_resp_q.delete();
                act_resp_q.delete();
                exp_l2_q.delete();
                act_l2_q.delete();
                exp_wr_q.delete();
                act_wr_q.delete();
        endtask

        task automatic load_table();
                rows[0]  = '{OP_READ, 52'ha11, 6'd5, 1'b0};
                names[0] = "read_cold";
                rows[1]  = '{OP_READ, 52'ha11, 6'd5, 1'b1};
                names[1] = "read_repeat";
                rows[2]  = '{OP_WRITE, 52'ha11, 6'd5, 1'b1};
                names[2] = "store_hit";
                rows[3]  = '{OP_READ, 52'hb22, 6'd5, 1'b0};
                names[3] = "evict_dirty";
                rows[4]  = '{OP_READ, 52'hc33, 6'd5, 1'b0};
                names[4] = "evict_clean";
                rows[5]  = '{OP_WRITE, 52'hd44, 6'd9, 1'b0};
                names[5] = "store_cold";
                rows[6]  = '{OP_FLUSH, 52'h0, 6'd0, 1'b0};
                names[6] = "flush_idle";
                rows[7]  = '{OP_READ, 52'hd44, 6'd9, 1'b0};
                names[7] = "flushed_dirty";
                rows[8]  = '{OP_READ, 52'hc33, 6'd5, 1'b0};
                names[8] = "flushed_clean";
                rows[9]  = '{OP_WRITE, 52'he55, 6'd9, 1'b0};
                names[9] = "store_miss";
                rows[10] = '{OP_READ, 52'ha11, 6'd9, 1'b0};
                names[10] = "evict_store_miss";
        endtask

        task automatic run_row(input int r);
                cpu_req_t req;
                logic     hit;
                start_test();
                if (rows[r].op == OP_FLUSH) begin
                        flush = 1'b1;
                        @(posedge clk);
                        #1;
                        flush = 1'b0;
                        model_valid = '0;
                end else begin
                        req = '{tag: rows[r].tag, index: rows[r].index,
                                write: rows[r].op == OP_WRITE};
                        model_access(req, hit);
                        check_bit({names[r], " model against table"}, rows[r].hit, hit);
                        send_req(req);
                        wait_done();
                end
                finish_test(names[r]);
        endtask

        // outputs read at the edge still hold the value of the cycle before
        always @(posedge clk) begin
                if (nrst) begin
                        if (credit_return) begin
                                credits++;
                        end
                        if (credits > `L1_QUEUE_DEPTH) begin
                                $display("more credits came back than were taken");
                                test_errors++;
                        end
                        if (resp_valid) begin
                                act_resp_q.push_back(resp);
                        end
                        if (l2_ready && (l2_read || l2_write)) begin
                                act_l2_q.push_back(l2_req);
                                act_wr_q.push_back(l2_write);
                        end
                        saw_refill = saw_refill | refill;
                        saw_update = saw_update | update;
                        saw_stall = saw_stall | stall;
                end
        end

        // L2 answers each held request after 0 to 7 cycles
        always @(posedge clk) begin
                #1;
                if (l2_ready) begin
                        l2_ready = 1'b0;
                        waiting = 1'b0;
                end else if (nrst && (l2_read || l2_write)) begin
                        if (!waiting) begin
                                draw_bits(delay_lfsr, 3, wait_cnt);
                                waiting = 1'b1;
                        end
                        if (wait_cnt == 0) begin
                                l2_ready = 1'b1;
                        end else begin
                                wait_cnt--;
                        end
                end
        end

        initial begin
                cpu_req_t req;
                logic     hit;
                int       v;
                int       n;
                flush = 1'b0;
                cpu_req = '0;
                cpu_req_valid = 1'b0;
                l2_ready = 1'b0;
                waiting = 1'b0;
                wait_cnt = 0;
                credits = `L1_QUEUE_DEPTH;
                total_errors = 0;
                failed_tests = 0;
                n_tests = 0;
                test_errors = 0;
                timed_out = 1'b0;
                model_valid = '0;
                model_dirty = '0;
                stim_lfsr = 16'd35661;
                delay_lfsr = 16'd35661;
                load_table();
                start_test();
                n = 0;
                while (nrst !== 1'b1 && n < 100) begin
                        @(posedge clk);
                        n++;
                end
                if (nrst !== 1'b1) begin
                        $display("timeout: reset was never released");
                        timed_out = 1'b1;
                end
                @(posedge clk);
                #1;
                check_bit("reset stall", 1'b0, stall);
                check_bit("reset refill", 1'b0, refill);
                check_bit("reset update", 1'b0, update);
                check_bit("reset l2_read", 1'b0, l2_read);
                check_bit("reset l2_write", 1'b0, l2_write);
                check_bit("reset resp_valid", 1'b0, resp_valid);
                check_bit("reset credit_return", 1'b0, credit_return);
                finish_test("reset");
                for (int r = 0; r < N_ROWS; r++) begin
                        if (!timed_out) begin
                                run_row(r);
                        end
                end
                // back to back requests on a few sets with tags that often repeat
                for (int b = 0; b < N_BURSTS; b++) begin
                        if (!timed_out) begin
                                start_test();
                                for (int k = 0; k < `L1_QUEUE_DEPTH; k++) begin
                                        draw_bits(stim_lfsr, 2, v);
                                        req.index = burst_index[v];
                                        draw_bits(stim_lfsr, 2, v);
                                        req.tag = 'h100 + v;
                                        draw_bits(stim_lfsr, 1, v);
                                        req.write = v[0];
                                        model_access(req, hit);
                                        send_req(req);
                                end
                                wait_done();
                                finish_test($sformatf("burst_%0d", b));
                        end
                end
                $display("tests %0d, failed %0d, errors %0d", n_tests, failed_tests, total_errors);
                if (total_errors == 0 && !timed_out) begin
                        $display("STATUS: PASS");
                end else begin
                        $display("STATUS: FAIL");
                end
                $finish;
        end

endmodule

// File: l1_dcache.f
+incdir+logic
logic/l1_dcache_pkg.sv
logic/l1_request_queue.sv
logic/l1_tag_array.sv
logic/l1_miss_controller.sv
logic/l1_dcache.sv
tb/l1_dcache_clock_gen.sv
tb/l1_dcache_tb.sv

// File: Bender.yml
package:
  name: l1_dcache

sources:
  - include_dirs:
      - logic
    files:
      - logic/l1_dcache_pkg.sv
      - logic/l1_request_queue.sv
      - logic/l1_tag_array.sv
      - logic/l1_miss_controller.sv
      - logic/l1_dcache.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/l1_dcache_clock_gen.sv
      - tb/l1_dcache_tb.sv
